// ==== include/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////////////////////////

`define ICACHE_WAYS 4
`define ICACHE_SETS 128

// physical tag above set and line offset
`define ICACHE_TAG_W 20
`define ICACHE_SET_W 7

//////////////////////////////////////////////////////////////////////
// refill and reset
//////////////////////////////////////////////////////////////////////

// 32-bit words per line, one burst beat each
`define ICACHE_LINE_WORDS 8

// one set invalidated per cycle
`define ICACHE_SWEEP_CYCLES 128

`endif

// ==== rtl/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]         tag_t;
    typedef logic [`ICACHE_SET_W-1:0]         set_t;
    typedef logic                             half_t;
    typedef logic [31:0]                      word_t;
    typedef logic [`ICACHE_LINE_WORDS*16-1:0] half_line_t;
    typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;
    typedef logic [`ICACHE_WAYS-1:0]          way_mask_t;

    // tree bits of one set
    typedef logic [`ICACHE_WAYS-2:0]          plru_t;

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        RUN,
        MISS,
        REFILL,
        FINISH,
        RECOVER
    } cache_state_t;

    // request in flight through tag and data stages
    typedef struct packed {
        logic  valid;
        set_t  set;
        half_t half;
        tag_t  tag;
    } stage_t;

endpackage

// ==== rtl/axi_rd_pkg.sv ====
package axi_rd_pkg;

    // read address, always aligned to a half-line
    typedef struct packed {
        icache_pkg::tag_t  tag;
        icache_pkg::set_t  set;
        icache_pkg::half_t half;
        logic [3:0]        offset;
    } ar_req_t;

    // one beat of the wrapping burst
    typedef struct packed {
        icache_pkg::word_t data;
        logic              last;
    } r_beat_t;

endpackage

// ==== rtl/icache_fsm.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     miss,
    input  logic                     arready,
    input  logic                     r_last_beat,
    output icache_pkg::cache_state_t state,
    output logic                     sweep,
    output icache_pkg::set_t         sweep_set,
    output logic                     fill
);

    icache_pkg::cache_state_t next_state;
    icache_pkg::set_t         sweep_cnt;
    logic                     sweep_done;

    assign sweep_done = (sweep_cnt == icache_pkg::set_t'(`ICACHE_SWEEP_CYCLES - 1));

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::SWEEP: begin
                if (sweep_done) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            icache_pkg::IDLE: begin
                next_state = icache_pkg::RUN;
            end
            icache_pkg::RUN: begin
                if (miss) begin
                    next_state = icache_pkg::MISS;
                end
            end
            icache_pkg::MISS: begin
                if (arready) begin
                    next_state = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                if (r_last_beat) begin
                    next_state = icache_pkg::FINISH;
                end
            end
            // answer and write, then re-read the stalled set
            icache_pkg::FINISH: begin
                next_state = icache_pkg::RECOVER;
            end
            icache_pkg::RECOVER: begin
                next_state = icache_pkg::IDLE;
            end
            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= icache_pkg::SWEEP;
        end else begin
            state <= next_state;
        end
    end

    // sweep index
    always_ff @(posedge clk) begin
        if (!rst) begin
            sweep_cnt <= '0;
        end else if (state == icache_pkg::SWEEP) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    assign sweep     = (state == icache_pkg::SWEEP);
    assign sweep_set = sweep_cnt;
    assign fill      = (state == icache_pkg::FINISH);

endmodule

// ==== rtl/icache_refill_buffer.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  icache_pkg::cache_state_t state,
    input  icache_pkg::stage_t       miss_req,
    input  axi_rd_pkg::r_beat_t      r,
    input  logic                     rvalid,
    output icache_pkg::line_t        line,
    output icache_pkg::half_line_t   fill_half
);

    localparam int CNT_W  = $clog2(`ICACHE_LINE_WORDS);
    localparam int WORD_W = $bits(icache_pkg::word_t);
    localparam int HALF_W = $bits(icache_pkg::half_line_t);

    logic [CNT_W-1:0]  beat_cnt;
    logic              beat;
    icache_pkg::word_t words [`ICACHE_LINE_WORDS];

    assign beat = rvalid && (state == icache_pkg::REFILL);

    // burst wraps from the first word of the requested half
    always_ff @(posedge clk) begin
        if (!rst) begin
            beat_cnt <= '0;
        end else if (state == icache_pkg::MISS) begin
            beat_cnt <= {miss_req.half, {(CNT_W - 1){1'b0}}};
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            words[beat_cnt] <= r.data;
        end
    end

    always_comb begin
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            line[i*WORD_W +: WORD_W] = words[i];
        end
    end

    assign fill_half = miss_req.half ? line[HALF_W +: HALF_W] : line[0 +: HALF_W];

endmodule

// ==== rtl/icache_tag_array.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tag_array (
    input  logic                                clk,
    input  icache_pkg::set_t                    rd_set,
    input  logic                                sweep,
    input  icache_pkg::set_t                    sweep_set,
    input  logic                                fill,
    input  icache_pkg::way_mask_t               victim,
    input  icache_pkg::set_t                    fill_set,
    input  icache_pkg::tag_t                    fill_tag,
    output icache_pkg::tag_t [`ICACHE_WAYS-1:0] tags,
    output icache_pkg::way_mask_t               valids
);

    icache_pkg::tag_t        tag_mem   [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_mem [`ICACHE_WAYS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (fill && victim[w]) begin
                tag_mem[w][fill_set] <= fill_tag;
            end
            tags[w] <= tag_mem[w][rd_set];
        end
    end

    // sweep clears every way of one set
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (sweep) begin
                valid_mem[w][sweep_set] <= 1'b0;
            end else if (fill && victim[w]) begin
                valid_mem[w][fill_set] <= 1'b1;
            end
            valids[w] <= valid_mem[w][rd_set];
        end
    end

endmodule

// ==== rtl/icache_data_array.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_data_array (
    input  logic                                 clk,
    input  icache_pkg::set_t                     rd_set,
    input  logic                                 fill,
    input  icache_pkg::way_mask_t                victim,
    input  icache_pkg::set_t                     fill_set,
    input  icache_pkg::line_t                    line,
    output icache_pkg::line_t [`ICACHE_WAYS-1:0] lines
);

    icache_pkg::line_t mem [`ICACHE_WAYS][`ICACHE_SETS];

    // whole line written at once from the refill buffer
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (fill && victim[w]) begin
                mem[w][fill_set] <= line;
            end
            lines[w] <= mem[w][rd_set];
        end
    end

endmodule

// ==== rtl/icache_plru.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_plru (
    input  logic                     clk,
    input  logic                     rst,
    input  icache_pkg::cache_state_t state,
    input  logic                     miss,
    input  icache_pkg::set_t         miss_set,
    output icache_pkg::way_mask_t    victim
);

    icache_pkg::plru_t     tree [`ICACHE_SETS];
    icache_pkg::plru_t     cur;
    icache_pkg::way_mask_t pick;

    assign cur = tree[miss_set];

    // bit0 picks the pair, bit1 or bit2 the way inside it
    always_comb begin
        if (!cur[0]) begin
            pick = cur[1] ? 4'b0010 : 4'b0001;
        end else begin
            pick = cur[2] ? 4'b1000 : 4'b0100;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= '0;
        end else if ((state == icache_pkg::RUN) && miss) begin
            victim <= pick;
        end
    end

    // point the tree away from the way just filled
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (state == icache_pkg::MISS) begin
            case (victim)
                4'b0001: tree[miss_set] <= {cur[2], 1'b1, 1'b1};
                4'b0010: tree[miss_set] <= {cur[2], 1'b0, 1'b1};
                4'b0100: tree[miss_set] <= {1'b1, cur[1], 1'b0};
                4'b1000: tree[miss_set] <= {1'b0, cur[1], 1'b0};
                default: tree[miss_set] <= cur;
            endcase
        end
    end

endmodule

// ==== rtl/icache_pipe.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_pipe (
    input  logic                                 clk,
    input  logic                                 rst,
    input  icache_pkg::cache_state_t             state,
    input  icache_pkg::set_t                     sweep_set,
    input  logic                                 req,
    input  logic [`ICACHE_SET_W:0]               index,
    input  icache_pkg::tag_t                     tag,
    input  icache_pkg::tag_t [`ICACHE_WAYS-1:0]  tags,
    input  icache_pkg::way_mask_t                valids,
    input  icache_pkg::line_t [`ICACHE_WAYS-1:0] lines,
    input  icache_pkg::half_line_t               fill_half,
    input  icache_pkg::set_t                     fill_set,
    output icache_pkg::set_t                     rd_set,
    output logic                                 index_ok,
    output logic                                 data_ok,
    output icache_pkg::half_line_t               rdata,
    output logic                                 miss,
    output icache_pkg::stage_t                   miss_req
);

    localparam int HALF_W = $bits(icache_pkg::half_line_t);

    icache_pkg::stage_t                   t_stage;
    icache_pkg::stage_t                   d_stage;
    logic                                 t_fresh;
    icache_pkg::tag_t                     t_tag;
    logic                                 run;
    logic                                 accept;
    logic                                 d_load;
    icache_pkg::tag_t [`ICACHE_WAYS-1:0]  d_tags;
    icache_pkg::way_mask_t                d_valids;
    icache_pkg::line_t [`ICACHE_WAYS-1:0] d_lines;
    icache_pkg::way_mask_t                hit_way;
    icache_pkg::line_t                    hit_line;

    assign run      = (state == icache_pkg::RUN);
    assign index_ok = run && (!d_stage.valid || data_ok);
    assign accept   = req && index_ok;
    assign d_load   = (run || (state == icache_pkg::FINISH)) && (!d_stage.valid || data_ok);

    // tag arrives one cycle after the index
    assign t_tag = t_fresh ? tag : t_stage.tag;

    always_comb begin
        case (state)
            icache_pkg::SWEEP:   rd_set = sweep_set;
            icache_pkg::FINISH:  rd_set = fill_set;
            icache_pkg::RECOVER: rd_set = d_stage.set;
            default:             rd_set = accept ? index[`ICACHE_SET_W:1] : t_stage.set;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // tag and data stages
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            t_stage <= '0;
            d_stage <= '0;
            t_fresh <= 1'b0;
        end else begin
            t_fresh <= accept;
            if (accept) begin
                t_stage.valid <= 1'b1;
                t_stage.set   <= index[`ICACHE_SET_W:1];
                t_stage.half  <= index[0];
            end else begin
                if (d_load) begin
                    t_stage.valid <= 1'b0;
                end
                t_stage.tag <= t_tag;
            end
            if (d_load) begin
                d_stage <= '{valid: t_stage.valid, set: t_stage.set,
                             half: t_stage.half, tag: t_tag};
            end
        end
    end

    // IDLE picks up the re-read from RECOVER
    always_ff @(posedge clk) begin
        if (d_load || (state == icache_pkg::IDLE)) begin
            d_tags   <= tags;
            d_valids <= valids;
            d_lines  <= lines;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // hit and answer
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way[w] = d_valids[w] && (d_tags[w] == d_stage.tag);
            if (hit_way[w]) begin
                hit_line = d_lines[w];
            end
        end
    end

    assign miss     = run && d_stage.valid && !(|hit_way);
    assign data_ok  = d_stage.valid && ((run && (|hit_way)) || (state == icache_pkg::FINISH));
    assign miss_req = d_stage;

    assign rdata = (state == icache_pkg::FINISH) ? fill_half :
                   d_stage.half ? hit_line[HALF_W +: HALF_W] : hit_line[0 +: HALF_W];

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  logic [`ICACHE_SET_W:0] index,
    input  icache_pkg::tag_t       tag,
    output logic                   index_ok,
    output logic                   data_ok,
    output icache_pkg::half_line_t rdata,
    output axi_rd_pkg::ar_req_t    ar,
    output logic                   arvalid,
    input  logic                   arready,
    input  axi_rd_pkg::r_beat_t    r,
    input  logic                   rvalid,
    output logic                   rready
);

    icache_pkg::cache_state_t             state;
    logic                                 sweep;
    icache_pkg::set_t                     sweep_set;
    logic                                 fill;
    logic                                 miss;
    icache_pkg::stage_t                   miss_req;
    logic                                 r_last_beat;
    icache_pkg::set_t                     rd_set;
    icache_pkg::tag_t [`ICACHE_WAYS-1:0]  tags;
    icache_pkg::way_mask_t                valids;
    icache_pkg::line_t [`ICACHE_WAYS-1:0] lines;
    icache_pkg::way_mask_t                victim;
    icache_pkg::line_t                    fill_line;
    icache_pkg::half_line_t               fill_half;

    // one outstanding burst, address from the missed request
    assign arvalid     = (state == icache_pkg::MISS);
    assign rready      = (state == icache_pkg::REFILL);
    assign r_last_beat = rvalid && rready && r.last;
    assign ar          = '{tag: miss_req.tag, set: miss_req.set,
                           half: miss_req.half, offset: 4'b0000};

    icache_fsm u_fsm (
        .clk(clk), .rst(rst), .miss(miss), .arready(arready),
        .r_last_beat(r_last_beat), .state(state), .sweep(sweep),
        .sweep_set(sweep_set), .fill(fill)
    );

    icache_pipe u_pipe (
        .clk(clk), .rst(rst), .state(state), .sweep_set(sweep_set),
        .req(req), .index(index), .tag(tag), .tags(tags), .valids(valids),
        .lines(lines), .fill_half(fill_half), .fill_set(miss_req.set),
        .rd_set(rd_set), .index_ok(index_ok), .data_ok(data_ok),
        .rdata(rdata), .miss(miss), .miss_req(miss_req)
    );

    icache_tag_array u_tag_array (
        .clk(clk), .rd_set(rd_set), .sweep(sweep), .sweep_set(sweep_set),
        .fill(fill), .victim(victim), .fill_set(miss_req.set),
        .fill_tag(miss_req.tag), .tags(tags), .valids(valids)
    );

    icache_data_array u_data_array (
        .clk(clk), .rd_set(rd_set), .fill(fill), .victim(victim),
        .fill_set(miss_req.set), .line(fill_line), .lines(lines)
    );

    icache_refill_buffer u_refill_buffer (
        .clk(clk), .rst(rst), .state(state), .miss_req(miss_req), .r(r),
        .rvalid(rvalid), .line(fill_line), .fill_half(fill_half)
    );

    icache_plru u_plru (
        .clk(clk), .rst(rst), .state(state), .miss(miss),
        .miss_set(miss_req.set), .victim(victim)
    );

endmodule

// ==== sim/icache_checker.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  logic [`ICACHE_SET_W:0] index,
    input  icache_pkg::tag_t       tag,
    input  logic                   index_ok,
    input  logic                   data_ok,
    input  icache_pkg::half_line_t rdata,
    input  axi_rd_pkg::ar_req_t    ar,
    input  logic                   arvalid,
    input  logic                   arready,
    input  logic                   rready,
    input  logic                   stim_done,
    output int                     error_count,
    output logic                   report_done
);

    icache_pkg::tag_t   model_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic               model_valid [`ICACHE_SETS][`ICACHE_WAYS];
    icache_pkg::plru_t  model_tree  [`ICACHE_SETS];

    icache_pkg::stage_t pend_q [$];
    int                 acc_q  [$];
    logic [26:0]        seen_q [$];

    int                 pass_cnt [5];
    int                 fail_cnt [5];
    int                 cyc;
    int                 acc;
    int                 way;
    int                 total_pass;
    logic               tag_due;
    logic               ar_wait;
    logic               head_filled;
    logic               last_miss;
    icache_pkg::stage_t entry;
    icache_pkg::stage_t head;
    axi_rd_pkg::ar_req_t ar_held;
    axi_rd_pkg::ar_req_t exp_ar;
    icache_pkg::half_line_t exp_half;

    // same word contents as the read-slave model
    function automatic icache_pkg::word_t word_hash(input logic [29:0] waddr);
        icache_pkg::word_t h;
        h = {2'b00, waddr} * 32'h9e37_79b1;
        word_hash = h ^ {h[15:0], h[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic icache_pkg::half_line_t expected_half(input icache_pkg::stage_t s);
        icache_pkg::half_line_t h;
        logic [29:0]            base;
        base = {s.tag, s.set, s.half, 2'b00};
        for (int j = 0; j < 4; j++) begin
            h[j*32 +: 32] = word_hash(base + j);
        end
        expected_half = h;
    endfunction

    function automatic int find_way(input icache_pkg::set_t s, input icache_pkg::tag_t t);
        find_way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (model_valid[s][w] && (model_tag[s][w] == t)) begin
                find_way = w;
            end
        end
    endfunction

    function automatic logic line_is_new(input logic [26:0] key);
        line_is_new = 1'b1;
        foreach (seen_q[i]) begin
            if (seen_q[i] == key) begin
                line_is_new = 1'b0;
            end
        end
    endfunction

    function automatic string test_name(input int b);
        case (b)
            0: test_name = "reset sweep and first access";
            1: test_name = "answer data and order";
            2: test_name = "burst address and arvalid hold";
            3: test_name = "hit and miss prediction";
            default: test_name = "back to back hit latency";
        endcase
    endfunction

    task automatic tally(input int b, input logic ok);
        if (ok) begin
            pass_cnt[b]++;
        end else begin
            fail_cnt[b]++;
            error_count++;
        end
    endtask

    // tree PLRU victim, then point the tree away from it
    task automatic fill_model(input icache_pkg::set_t s, input icache_pkg::tag_t t);
        icache_pkg::plru_t bits;
        int                victim;
        bits = model_tree[s];
        if (!bits[0]) begin
            victim = bits[1] ? 1 : 0;
        end else begin
            victim = bits[2] ? 3 : 2;
        end
        case (victim)
            0: begin
                bits[0] = 1'b1;
                bits[1] = 1'b1;
            end
            1: begin
                bits[0] = 1'b1;
                bits[1] = 1'b0;
            end
            2: begin
                bits[0] = 1'b0;
                bits[2] = 1'b1;
            end
            default: begin
                bits[0] = 1'b0;
                bits[2] = 1'b0;
            end
        endcase
        model_tree[s] = bits;
        model_valid[s][victim] = 1'b1;
        model_tag[s][victim] = t;
    endtask

    initial begin
        error_count = 0;
        report_done = 1'b0;
        head_filled = 1'b0;
        last_miss   = 1'b0;
        for (int b = 0; b < 5; b++) begin
            pass_cnt[b] = 0;
            fail_cnt[b] = 0;
        end
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            model_tree[s] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w] = '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per-cycle checks
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            cyc     = 0;
            tag_due = 1'b0;
            ar_wait = 1'b0;
        end else begin
            if (cyc < `ICACHE_SWEEP_CYCLES) begin
                if (index_ok || data_ok || arvalid || rready) begin
                    $display("error: handshake output high in sweep cycle %0d", cyc);
                    tally(0, 1'b0);
                end else begin
                    tally(0, 1'b1);
                end
            end

            // tag of the request accepted last cycle
            if (tag_due && (pend_q.size() > 0)) begin
                entry = pend_q.pop_back();
                entry.tag = tag;
                pend_q.push_back(entry);
            end

            if (ar_wait && !arvalid) begin
                $display("error: arvalid dropped before arready");
                tally(2, 1'b0);
            end else if (ar_wait && (ar !== ar_held)) begin
                $display("Fail ar: expected %h, actual %h", ar_held, ar);
                tally(2, 1'b0);
            end

            if (arvalid && arready) begin
                if ((pend_q.size() == 0) || head_filled) begin
                    $display("error: burst issued with no missed request waiting");
                    tally(2, 1'b0);
                end else begin
                    head = pend_q[0];
                    exp_ar.tag    = head.tag;
                    exp_ar.set    = head.set;
                    exp_ar.half   = head.half;
                    exp_ar.offset = 4'h0;
                    if (ar !== exp_ar) begin
                        $display("Fail ar: expected %h, actual %h", exp_ar, ar);
                    end
                    tally(2, ar === exp_ar);
                    if (find_way(head.set, head.tag) >= 0) begin
                        $display("error: burst for set %h tag %h, model predicts a hit",
                                 head.set, head.tag);
                        tally(3, 1'b0);
                    end else begin
                        tally(3, 1'b1);
                        fill_model(head.set, head.tag);
                    end
                    if (line_is_new({head.tag, head.set})) begin
                        tally(0, 1'b1);
                        seen_q.push_back({head.tag, head.set});
                    end
                    head_filled = 1'b1;
                end
            end

            if (data_ok) begin
                if (pend_q.size() == 0) begin
                    $display("error: data_ok with no request outstanding");
                    tally(1, 1'b0);
                end else begin
                    head = pend_q.pop_front();
                    acc  = acc_q.pop_front();
                    if (!head_filled) begin
                        way = find_way(head.set, head.tag);
                        if (way < 0) begin
                            $display("error: set %h tag %h answered without a burst",
                                     head.set, head.tag);
                        end
                        tally(3, way >= 0);
                        if (line_is_new({head.tag, head.set})) begin
                            $display("error: first access to set %h tag %h did not miss",
                                     head.set, head.tag);
                            tally(0, 1'b0);
                            seen_q.push_back({head.tag, head.set});
                        end
                        // a hit behind a hit never waits
                        if (!last_miss) begin
                            if (cyc != acc + 2) begin
                                $display("error: hit accepted in cycle %0d answered in %0d",
                                         acc, cyc);
                            end
                            tally(4, cyc == acc + 2);
                        end
                    end
                    exp_half = expected_half(head);
                    if (rdata !== exp_half) begin
                        $display("Fail rdata: expected %h, actual %h", exp_half, rdata);
                    end
                    tally(1, rdata === exp_half);
                    last_miss   = head_filled;
                    head_filled = 1'b0;
                end
            end

            if (req && index_ok) begin
                entry.valid = 1'b1;
                entry.set   = index[`ICACHE_SET_W:1];
                entry.half  = index[0];
                entry.tag   = '0;
                pend_q.push_back(entry);
                acc_q.push_back(cyc);
            end

            tag_due = req && index_ok;
            ar_wait = arvalid && !arready;
            ar_held = ar;
            cyc++;

            if (stim_done && !report_done) begin
                if (pend_q.size() != 0) begin
                    $display("error: %0d accepted requests never answered", pend_q.size());
                    tally(1, 1'b0);
                end
                total_pass = 0;
                for (int b = 0; b < 5; b++) begin
                    $display("test %0d %s: %0d passed, %0d failed",
                             b + 1, test_name(b), pass_cnt[b], fail_cnt[b]);
                    total_pass += pass_cnt[b];
                end
                $display("checks: %0d passed, %0d failed", total_pass, error_count);
                report_done = 1'b1;
            end
        end
    end

endmodule

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb;

    localparam int NUM_REQS       = 400;
    localparam int TIMEOUT_CYCLES = `ICACHE_SWEEP_CYCLES + NUM_REQS * 40;

    logic                   clk;
    logic                   rst;
    logic                   req;
    logic [`ICACHE_SET_W:0] index;
    icache_pkg::tag_t       tag;
    logic                   index_ok;
    logic                   data_ok;
    icache_pkg::half_line_t rdata;
    axi_rd_pkg::ar_req_t    ar;
    logic                   arvalid;
    logic                   arready;
    axi_rd_pkg::r_beat_t    r;
    logic                   rvalid;
    logic                   rready;
    logic                   stim_done;
    logic                   report_done;
    int                     error_count;
    int                     answered = 0;
    int                     cycle_cnt = 0;

    // few sets and tags so that lines collide and get evicted
    icache_pkg::set_t set_vals [4] = '{7'h05, 7'h25, 7'h40, 7'h7f};
    icache_pkg::tag_t tag_vals [6] = '{20'h00000, 20'h00001, 20'h12345,
                                       20'h80000, 20'hfffff, 20'h0a5a5};

    function automatic icache_pkg::word_t word_hash(input logic [29:0] waddr);
        icache_pkg::word_t h;
        h = {2'b00, waddr} * 32'h9e37_79b1;
        word_hash = h ^ {h[15:0], h[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    task automatic skip_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    icache_top UUT (
        .clk(clk), .rst(rst), .req(req), .index(index), .tag(tag),
        .index_ok(index_ok), .data_ok(data_ok), .rdata(rdata),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready)
    );

    icache_checker scoreboard (
        .clk(clk), .rst(rst), .req(req), .index(index), .tag(tag),
        .index_ok(index_ok), .data_ok(data_ok), .rdata(rdata),
        .ar(ar), .arvalid(arvalid), .arready(arready), .rready(rready),
        .stim_done(stim_done), .error_count(error_count), .report_done(report_done)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rst && data_ok) begin
            answered++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("error: run timed out after %0d cycles, %0d of %0d requests answered",
                     cycle_cnt, answered, NUM_REQS);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // processor side
    //////////////////////////////////////////////////////////////////////

    initial begin
        int               accepted;
        int               gap;
        logic             took;
        logic             pick_half;
        icache_pkg::tag_t req_tag;
        void'($urandom(97130));
        rst       = 1'b0;
        req       = 1'b0;
        index     = '0;
        tag       = '0;
        arready   = 1'b0;
        r         = '0;
        rvalid    = 1'b0;
        stim_done = 1'b0;
        accepted  = 0;
        req_tag   = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        gap = $urandom_range(0, 3);
        while (accepted < NUM_REQS) begin
            @(posedge clk);
            took = req && index_ok;
            #2;
            // junk tag except right after acceptance
            tag = icache_pkg::tag_t'($urandom);
            if (took) begin
                tag = req_tag;
                accepted++;
                req = 1'b0;
                gap = $urandom_range(0, 3);
            end
            if (!req && (accepted < NUM_REQS)) begin
                if (gap == 0) begin
                    pick_half = $urandom_range(0, 1);
                    index     = {set_vals[$urandom_range(0, 3)], pick_half};
                    req_tag   = tag_vals[$urandom_range(0, 5)];
                    req       = 1'b1;
                end else begin
                    gap--;
                end
            end
        end
        while (answered < NUM_REQS) begin
            @(posedge clk);
        end
        skip_cycles(4);
        stim_done = 1'b1;
        wait (report_done === 1'b1);
        #1;
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // AXI read slave
    //////////////////////////////////////////////////////////////////////

    initial begin
        axi_rd_pkg::ar_req_t burst;
        logic [2:0]          widx;
        forever begin
            @(posedge clk);
            if (rst && arvalid) begin
                repeat ($urandom_range(0, 3)) @(posedge clk);
                #2;
                arready = 1'b1;
                @(posedge clk);
                burst = ar;
                #2;
                arready = 1'b0;
                // wrap order from the first word of the half
                for (int beat = 0; beat < `ICACHE_LINE_WORDS; beat++) begin
                    skip_cycles($urandom_range(0, 2));
                    widx   = {burst.half, 2'b00} + beat[2:0];
                    r.data = word_hash({burst.tag, burst.set, widx});
                    r.last = (beat == `ICACHE_LINE_WORDS - 1);
                    rvalid = 1'b1;
                    do begin
                        @(posedge clk);
                    end while (!rready);
                    #2;
                    rvalid = 1'b0;
                end
            end
        end
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/icache_pkg.sv
rtl/axi_rd_pkg.sv
rtl/icache_fsm.sv
rtl/icache_refill_buffer.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_plru.sv
rtl/icache_pipe.sv
rtl/icache_top.sv
sim/icache_checker.sv
sim/icache_tb.sv
